// ==== lsu_top.f ====
+incdir+common
+incdir+sim
common/lsu_pkg.sv
common/mem_req_if.sv
lsu/lsu_issue.sv
lsu/lsu_req_fifo.sv
lsu/lsu_dmem.sv
verilog/lsu_top.sv
sim/tb_lsu_top.sv

// ==== Bender.yml ====
package:
  name: lsu_top

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lsu_pkg.sv
      - common/mem_req_if.sv
      - lsu/lsu_issue.sv
      - lsu/lsu_req_fifo.sv
      - lsu/lsu_dmem.sv
      - verilog/lsu_top.sv

  - target: test
    include_dirs:
      - common
      - sim
    files:
      - sim/tb_lsu_top.sv

// ==== sim/tb_lsu_vectors.svh ====
`ifndef TB_LSU_VECTORS_SVH
`define TB_LSU_VECTORS_SVH

// columns: op, byte address, rs2 value, expected load data, expected misaligned flag
// store rows carry zero as expected data, misaligned rows make no response
typedef struct packed {
  lsu_op_e     op;
  logic [31:0] addr;
  logic [31:0] src2;
  logic [31:0] exp_data;
  logic        exp_mis;
} vec_t;

localparam int NUM_VECS = 43;

// rows from here on are driven with no idle gap
localparam int BURST_START = 36;

localparam vec_t VECS [NUM_VECS] = '{
  '{SW,   32'h0000_0010, 32'hdead_beef, 32'h0000_0000, 1'b0},
  '{LW,   32'h0000_0010, 32'h0000_0000, 32'hdead_beef, 1'b0},
  '{LW,   32'h0000_03fc, 32'h0000_0000, 32'h0000_0000, 1'b0},
  '{SW,   32'h0000_0020, 32'h1122_3344, 32'h0000_0000, 1'b0},
  '{SB,   32'h0000_0020, 32'h0000_00a5, 32'h0000_0000, 1'b0},
  '{SB,   32'h0000_0021, 32'h0000_005a, 32'h0000_0000, 1'b0},
  '{SB,   32'h0000_0022, 32'h0000_0077, 32'h0000_0000, 1'b0},
  '{SB,   32'h0000_0023, 32'h0000_00c3, 32'h0000_0000, 1'b0},
  '{LW,   32'h0000_0020, 32'h0000_0000, 32'hc377_5aa5, 1'b0},
  '{SH,   32'h0000_0030, 32'hffff_8001, 32'h0000_0000, 1'b0},
  '{LW,   32'h0000_0030, 32'h0000_0000, 32'h0000_8001, 1'b0},
  '{SH,   32'h0000_0032, 32'h1234_beef, 32'h0000_0000, 1'b0},
  '{LW,   32'h0000_0030, 32'h0000_0000, 32'hbeef_8001, 1'b0},
  '{LB,   32'h0000_0020, 32'h0000_0000, 32'hffff_ffa5, 1'b0},
  '{LB,   32'h0000_0021, 32'h0000_0000, 32'h0000_005a, 1'b0},
  '{LB,   32'h0000_0022, 32'h0000_0000, 32'h0000_0077, 1'b0},
  '{LB,   32'h0000_0023, 32'h0000_0000, 32'hffff_ffc3, 1'b0},
  '{LBU,  32'h0000_0020, 32'h0000_0000, 32'h0000_00a5, 1'b0},
  '{LBU,  32'h0000_0021, 32'h0000_0000, 32'h0000_005a, 1'b0},
  '{LBU,  32'h0000_0022, 32'h0000_0000, 32'h0000_0077, 1'b0},
  '{LBU,  32'h0000_0023, 32'h0000_0000, 32'h0000_00c3, 1'b0},
  '{LH,   32'h0000_0020, 32'h0000_0000, 32'h0000_5aa5, 1'b0},
  '{LH,   32'h0000_0022, 32'h0000_0000, 32'hffff_c377, 1'b0},
  '{LHU,  32'h0000_0020, 32'h0000_0000, 32'h0000_5aa5, 1'b0},
  '{LHU,  32'h0000_0022, 32'h0000_0000, 32'h0000_c377, 1'b0},
  '{LH,   32'h0000_0030, 32'h0000_0000, 32'hffff_8001, 1'b0},
  '{LHU,  32'h0000_0032, 32'h0000_0000, 32'h0000_beef, 1'b0},
  '{LH,   32'h0000_0021, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{LW,   32'h0000_0022, 32'h0000_0000, 32'h0000_0000, 1'b1},
  '{SW,   32'h0000_0012, 32'hffff_ffff, 32'h0000_0000, 1'b1},
  '{SH,   32'h0000_0013, 32'h0000_ffff, 32'h0000_0000, 1'b1},
  '{LW,   32'h0000_0010, 32'h0000_0000, 32'hdead_beef, 1'b0},
  '{NONE, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0},
  '{SW,   32'h0000_0440, 32'hcafe_f00d, 32'h0000_0000, 1'b0},
  '{LW,   32'h0000_0040, 32'h0000_0000, 32'hcafe_f00d, 1'b0},
  '{LB,   32'h8000_0443, 32'h0000_0000, 32'hffff_ffca, 1'b0},
  '{SW,   32'h0000_0080, 32'h0102_0304, 32'h0000_0000, 1'b0},
  '{SB,   32'h0000_0081, 32'h0000_00ff, 32'h0000_0000, 1'b0},
  '{LW,   32'h0000_0080, 32'h0000_0000, 32'h0102_ff04, 1'b0},
  '{SH,   32'h0000_0082, 32'h0000_abcd, 32'h0000_0000, 1'b0},
  '{LHU,  32'h0000_0082, 32'h0000_0000, 32'h0000_abcd, 1'b0},
  '{LB,   32'h0000_0081, 32'h0000_0000, 32'hffff_ffff, 1'b0},
  '{LW,   32'h0000_0080, 32'h0000_0000, 32'habcd_ff04, 1'b0}
};

`endif

// ==== sim/tb_lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module tb_lsu_top import lsu_pkg::*; ();

  `include "tb_lsu_vectors.svh"

  // reset sweep plus a generous per-row budget
  localparam int CYCLE_LIMIT = NUM_VECS * 40 + 400;

  logic                 i_clk;
  logic                 i_rst;
  logic                 i_valid;
  lsu_op_e              i_op;
  logic [`LSU_XLEN-1:0] i_addr;
  logic [`LSU_XLEN-1:0] i_src2;
  logic                 o_ready;
  logic                 o_rsp_valid;
  logic [`LSU_XLEN-1:0] o_rsp_data;
  logic                 o_misaligned;

  // expected load results in acceptance order
  logic [31:0] exp_q [$];
  logic [31:0] exp_data;
  logic [31:0] lfsr;
  int          cycles;
  int          data_errs;
  int          flag_errs;
  int          ready_errs;
  int          order_errs;

  lsu_top DUT (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_op         (i_op),
    .i_addr       (i_addr),
    .i_src2       (i_src2),
    .o_ready      (o_ready),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_data   (o_rsp_data),
    .o_misaligned (o_misaligned)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // 0 to 3 idle cycles, two lfsr bits
  task automatic idle_gap();
    int gap;
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_step(lfsr);
      gap  = (gap << 1) | int'(lfsr[0]);
    end
    repeat (gap) @(posedge i_clk);
  endtask

  // present one row and hold it until the issue stage takes it
  task automatic apply_row(input vec_t v);
    @(posedge i_clk);
    i_valid <= 1'b1;
    i_op    <= v.op;
    i_addr  <= v.addr;
    i_src2  <= v.src2;
    @(negedge i_clk);
    while (!o_ready) @(negedge i_clk);
    // accepted on this edge
    @(posedge i_clk);
    i_valid <= 1'b0;
    if (lsu_is_load(v.op) && !v.exp_mis) exp_q.push_back(v.exp_data);
    // flag belongs to the cycle after acceptance
    @(negedge i_clk);
    assert (o_misaligned === v.exp_mis) else begin
      flag_errs++;
      $display("ERROR: o_misaligned got %h expected %h addr %h", o_misaligned, v.exp_mis,
               v.addr);
    end
    // issue stage is busy with the op it just took
    assert (o_ready === 1'b0) else begin
      ready_errs++;
      $display("ERROR: o_ready got %h expected %h addr %h", o_ready, 1'b0, v.addr);
    end
  endtask

  // scoreboard on the stable half of the cycle
  always @(negedge i_clk) begin
    if (!i_rst && o_rsp_valid) begin
      assert (exp_q.size() != 0) else begin
        order_errs++;
        $display("load result arrived while no load was outstanding");
      end
      if (exp_q.size() != 0) begin
        exp_data = exp_q.pop_front();
        assert (o_rsp_data === exp_data) else begin
          data_errs++;
          $display("ERROR: o_rsp_data got %h expected %h", o_rsp_data, exp_data);
        end
      end
    end
  end

  // run limit
  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the run did not complete", cycles);
      $display("errors: data %0d, misaligned %0d, ready %0d, unexpected %0d, timeout 1",
               data_errs, flag_errs, ready_errs, order_errs);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    i_rst      = 1'b1;
    i_valid    = 1'b0;
    i_op       = NONE;
    i_addr     = '0;
    i_src2     = '0;
    lfsr       = 32'hb199_e33b;
    cycles     = 0;
    data_errs  = 0;
    flag_errs  = 0;
    ready_errs = 0;
    order_errs = 0;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    // first row waits out the memory clear through o_ready
    for (int i = 0; i < NUM_VECS; i++) begin
      apply_row(VECS[i]);
      if (i + 1 < BURST_START) idle_gap();
    end
    // drain, then leave room for any stray response
    while (exp_q.size() != 0) @(negedge i_clk);
    repeat (20) @(negedge i_clk);
    $display("errors: data %0d, misaligned %0d, ready %0d, unexpected %0d, timeout 0",
             data_errs, flag_errs, ready_errs, order_errs);
    if (data_errs + flag_errs + ready_errs + order_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst,
  // operation from execute
  input  logic                 i_valid,
  input  lsu_op_e              i_op,
  input  logic [`LSU_XLEN-1:0] i_addr,
  input  logic [`LSU_XLEN-1:0] i_src2,
  output logic                 o_ready,
  // load result to writeback, no back-pressure
  output logic                 o_rsp_valid,
  output logic [`LSU_XLEN-1:0] o_rsp_data,
  output logic                 o_misaligned
);

  // memory clear sweep finished
  logic mem_ready;

  // issue -> queue
  mem_req_if #(.T(mem_req_t)) q_in ();
  // queue -> memory
  mem_req_if #(.T(mem_req_t)) q_out ();

  lsu_issue u_issue (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_op         (i_op),
    .i_addr       (i_addr),
    .i_src2       (i_src2),
    .i_mem_ready  (mem_ready),
    .o_ready      (o_ready),
    .o_misaligned (o_misaligned),
    .q            (q_in.issuer)
  );

  // keeps several requests in flight, strict order
  lsu_req_fifo #(
    .T (mem_req_t)
  ) u_fifo (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .s_in  (q_in.server),
    .s_out (q_out.issuer)
  );

  lsu_dmem u_dmem (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .o_init_done (mem_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_data  (o_rsp_data),
    .s           (q_out.server)
  );

endmodule

// ==== lsu/lsu_dmem.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_dmem import lsu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst,
  output logic                 o_init_done,
  output logic                 o_rsp_valid,
  output logic [`LSU_XLEN-1:0] o_rsp_data,
  mem_req_if.server            s
);

  localparam int unsigned WORDS  = `LSU_DMEM_WORDS;
  localparam int unsigned IDX_W  = $clog2(WORDS);
  localparam int unsigned STRB_W = `LSU_STRB_W;

  logic [`LSU_XLEN-1:0] mem [WORDS];

  // clear sweep after reset
  logic [IDX_W-1:0]     init_idx;
  logic                 init_done;

  logic                 ack;
  logic                 accept;
  logic [IDX_W-1:0]     req_idx;

  // shared write port, sweep or store
  logic                 wr_en;
  logic [IDX_W-1:0]     wr_idx;
  logic [`LSU_XLEN-1:0] wr_data;
  logic [STRB_W-1:0]    wr_strb;

  // load path
  logic [`LSU_XLEN-1:0] rdata;
  lsu_op_e              rsp_op;
  logic [1:0]           rsp_off;
  logic                 rsp_valid;
  logic [`LSU_XLEN-1:0] shifted;

  // upper address bits drop out here, hence the aliasing
  assign req_idx = s.payload.widx[IDX_W-1:0];
  assign accept  = init_done && s.req && !ack;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      init_idx  <= '0;
      init_done <= 1'b0;
    end else if (!init_done) begin
      init_idx <= init_idx + 1'b1;
      if (init_idx == IDX_W'(WORDS - 1)) init_done <= 1'b1;
    end
  end

  assign wr_en   = !init_done || (accept && s.payload.store);
  assign wr_idx  = init_done ? req_idx : init_idx;
  assign wr_data = init_done ? s.payload.wdata : '0;
  assign wr_strb = init_done ? s.payload.wstrb : '1;

  // sram with per-lane enables, one-cycle read
  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr_strb[i]) mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
      end
    end
    if (accept && !s.payload.store) rdata <= mem[req_idx];
  end

  // ack one cycle after req, dropped once req is gone
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ack       <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= accept && !s.payload.store;
      if (accept) ack <= 1'b1;
      else if (ack && !s.req) ack <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      rsp_op  <= s.payload.op;
      rsp_off <= s.payload.offset;
    end
  end

  assign s.ack       = ack;
  assign o_init_done = init_done;
  assign o_rsp_valid = rsp_valid;

  // bring the addressed lane down to bit 0
  assign shifted = rdata >> {rsp_off, 3'b000};

  always_comb begin
    case (rsp_op)
      LB:      o_rsp_data = {{(`LSU_XLEN - 8){shifted[7]}}, shifted[7:0]};
      LH:      o_rsp_data = {{(`LSU_XLEN - 16){shifted[15]}}, shifted[15:0]};
      LW:      o_rsp_data = rdata;
      LBU:     o_rsp_data = {{(`LSU_XLEN - 8){1'b0}}, shifted[7:0]};
      LHU:     o_rsp_data = {{(`LSU_XLEN - 16){1'b0}}, shifted[15:0]};
      default: o_rsp_data = '0;
    endcase
  end

  // issue stage must hand us a real strobe for every store
  a_store_strobe: assert property (
    @(posedge i_clk) disable iff (i_rst)
    s.req && s.payload.store |-> (s.payload.wstrb != '0)
  );

endmodule

// ==== lsu/lsu_req_fifo.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_req_fifo import lsu_pkg::*; #(
  parameter type T = mem_req_t
) (
  input  logic      i_clk,
  input  logic      i_rst,
  mem_req_if.server s_in,
  mem_req_if.issuer s_out
);

  localparam int unsigned DEPTH = `LSU_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef enum logic {
    IN_IDLE,
    IN_ACK
  } in_state_e;

  typedef enum logic [1:0] {
    OUT_IDLE,
    OUT_REQ,
    OUT_DRAIN
  } out_state_e;

  T             mem [DEPTH];
  // head copy that stays put while req/ack are up
  T             head_q;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  in_state_e    in_state;
  out_state_e   out_state;
  logic         full;
  logic         push;
  logic         pop;

  function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full = (count == CNT_W'(DEPTH));
  // no ack without room, that stalls the issue stage
  assign push = (in_state == IN_IDLE) && s_in.req && !full;
  // head leaves as soon as memory acks it
  assign pop  = (out_state == OUT_REQ) && s_out.ack;

  // write side
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      in_state <= IN_IDLE;
      wr_ptr   <= '0;
    end else begin
      case (in_state)
        IN_IDLE: if (push) begin
          in_state <= IN_ACK;
          wr_ptr   <= ptr_next(wr_ptr);
        end
        default: if (!s_in.req) in_state <= IN_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) mem[wr_ptr] <= s_in.payload;
  end

  assign s_in.ack = (in_state == IN_ACK);

  // read side
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      out_state <= OUT_IDLE;
      rd_ptr    <= '0;
    end else begin
      case (out_state)
        OUT_IDLE: if (count != '0) out_state <= OUT_REQ;
        OUT_REQ: if (s_out.ack) begin
          out_state <= OUT_DRAIN;
          rd_ptr    <= ptr_next(rd_ptr);
        end
        default: if (!s_out.ack) out_state <= OUT_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((out_state == OUT_IDLE) && (count != '0)) head_q <= mem[rd_ptr];
  end

  assign s_out.req     = (out_state == OUT_REQ);
  assign s_out.payload = head_q;

  // occupancy
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      count <= '0;
    end else if (push && !pop) begin
      count <= count + 1'b1;
    end else if (pop && !push) begin
      count <= count - 1'b1;
    end
  end

  // pointers meeting with entries held means every slot is taken
  a_no_overflow: assert property (
    @(posedge i_clk) disable iff (i_rst)
    push |-> !((wr_ptr == rd_ptr) && (count != '0))
  );

  // memory only acks an entry we actually hold
  a_no_underflow: assert property (
    @(posedge i_clk) disable iff (i_rst)
    $rose(s_out.ack) |-> (count != '0)
  );

endmodule

// ==== lsu/lsu_issue.sv ====
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_issue import lsu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_valid,
  input  lsu_op_e              i_op,
  input  logic [`LSU_XLEN-1:0] i_addr,
  input  logic [`LSU_XLEN-1:0] i_src2,
  input  logic                 i_mem_ready,
  output logic                 o_ready,
  output logic                 o_misaligned,
  mem_req_if.issuer            q
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CHECK,
    S_REQ,
    S_RELEASE
  } state_e;

  state_e               state;

  // accepted operation
  lsu_op_e              op_q;
  logic [`LSU_XLEN-1:0] addr_q;
  logic [`LSU_XLEN-1:0] src2_q;

  logic [2:0]           bytes;
  logic                 misaligned;
  logic                 is_mem_op;
  logic                 accept;

  // one op in flight, ready again once q_in is back to idle
  // memory must have finished its clear sweep
  assign o_ready = (state == S_IDLE) && i_mem_ready;
  assign accept  = i_valid && o_ready;

  always_ff @(posedge i_clk) begin
    if (accept) begin
      op_q   <= i_op;
      addr_q <= i_addr;
      src2_q <= i_src2;
    end
  end

  // halfwords need even addresses, words need offset zero
  assign bytes      = lsu_access_bytes(op_q);
  assign misaligned = ((bytes == 3'd2) && addr_q[0]) ||
                      ((bytes == 3'd4) && (addr_q[1:0] != 2'b00));
  assign is_mem_op  = lsu_is_load(op_q) || lsu_is_store(op_q);

  // flag pulses the cycle after acceptance
  assign o_misaligned = (state == S_CHECK) && misaligned;

  // handshake fsm
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) state <= S_CHECK;
        end
        S_CHECK: begin
          // bad or empty op is dropped here, no request
          if (misaligned || !is_mem_op) state <= S_IDLE;
          else state <= S_REQ;
        end
        S_REQ: begin
          if (q.ack) state <= S_RELEASE;
        end
        S_RELEASE: begin
          if (!q.ack) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign q.req = (state == S_REQ);

  // record built straight from the held op
  // held regs only load in idle so it is quiet during req/ack
  assign q.payload.store  = lsu_is_store(op_q);
  assign q.payload.op     = op_q;
  assign q.payload.widx   = addr_q[`LSU_XLEN-1:2];
  assign q.payload.offset = addr_q[1:0];
  assign q.payload.wdata  = lsu_lane_data(op_q, src2_q);
  assign q.payload.wstrb  = lsu_store_strobe(op_q, addr_q[1:0]);

  // payload held while the queue may still be capturing it
  a_payload_stable: assert property (
    @(posedge i_clk) disable iff (i_rst)
    q.req |=> !q.req || $stable(q.payload)
  );

  // queue never acks a request we did not make
  a_ack_needs_req: assert property (
    @(posedge i_clk) disable iff (i_rst)
    $rose(q.ack) |-> $past(q.req)
  );

endmodule

// ==== common/mem_req_if.sv ====
`timescale 1ns/1ps

// four-phase req/ack channel between the lsu blocks
// 1. issuer raises req with payload stable
// 2. server takes payload and raises ack
// 3. issuer drops req
// 4. server drops ack
// payload only moves while req and ack are both low
interface mem_req_if #(
  parameter type T = logic
);

  // driven by the issuer
  logic req;
  T     payload;

  // driven by the server
  logic ack;

  modport issuer (
    output req,
    output payload,
    input  ack
  );

  modport server (
    input  req,
    input  payload,
    output ack
  );

endinterface

// ==== common/lsu_pkg.sv ====
`include "lsu_config.svh"

package lsu_pkg;

  // memory operations from execute
  typedef enum logic [3:0] {
    NONE = 4'd0,
    LB   = 4'd1,
    LH   = 4'd2,
    LW   = 4'd3,
    LBU  = 4'd4,
    LHU  = 4'd5,
    SB   = 4'd6,
    SH   = 4'd7,
    SW   = 4'd8
  } lsu_op_e;

  // one queued memory access
  // wdata and wstrb already sit on the addressed lanes
  typedef struct packed {
    logic                     store;
    lsu_op_e                  op;
    logic [`LSU_XLEN-3:0]     widx;
    logic [1:0]               offset;
    logic [`LSU_XLEN-1:0]     wdata;
    logic [`LSU_STRB_W-1:0]   wstrb;
  } mem_req_t;

  function automatic logic lsu_is_store(lsu_op_e op);
    return op inside {SB, SH, SW};
  endfunction

  function automatic logic lsu_is_load(lsu_op_e op);
    return op inside {LB, LH, LW, LBU, LHU};
  endfunction

  // access size in bytes, zero for anything that is not a memory op
  function automatic logic [2:0] lsu_access_bytes(lsu_op_e op);
    case (op)
      LB, LBU, SB: return 3'd1;
      LH, LHU, SH: return 3'd2;
      LW, SW:      return 3'd4;
      default:     return 3'd0;
    endcase
  endfunction

  // copy the store value onto every lane it could land on
  function automatic logic [`LSU_XLEN-1:0] lsu_lane_data(lsu_op_e op,
                                                         logic [`LSU_XLEN-1:0] src);
    case (lsu_access_bytes(op))
      3'd1:    return {(`LSU_XLEN / 8){src[7:0]}};
      3'd2:    return {(`LSU_XLEN / 16){src[15:0]}};
      default: return src;
    endcase
  endfunction

  // byte strobe from size and offset, empty for loads
  function automatic logic [`LSU_STRB_W-1:0] lsu_store_strobe(lsu_op_e op, logic [1:0] off);
    logic [`LSU_STRB_W-1:0] strb;
    strb = '0;
    if (lsu_is_store(op)) begin
      case (lsu_access_bytes(op))
        3'd1:    strb[0] = 1'b1;
        3'd2:    strb[1:0] = 2'b11;
        default: strb = '1;
      endcase
      strb = strb << off;
    end
    return strb;
  endfunction

endpackage

// ==== common/lsu_config.svh ====
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// sizing for the load/store unit and its data memory

// data and address width
`define LSU_XLEN 32

// byte lanes per data word
`define LSU_STRB_W (`LSU_XLEN / 8)

// data memory size in words
// word index comes from the address bits above the byte offset
// higher address bits alias back onto the array
`define LSU_DMEM_WORDS 256

// entries in the request queue between issue and memory
`define LSU_FIFO_DEPTH 4

`endif
